/* verification/decodePatterns.txt */
// instruction pc status hazard exeCmd writeBack memRead memWrite branch sFlag twoSrc dest src2Reg rn
// status is NZCV, all other columns in hex
E3A01005 00000100 0 0 1 1 0 0 0 0 0 1 5 0
E0923004 00000104 0 0 2 1 0 0 0 1 1 3 4 2
E24560FF 00000108 0 0 4 1 0 0 0 0 0 6 F 5
E0A78009 0000010C 0 0 3 1 0 0 0 0 1 8 9 7
00923004 00000110 0 0 0 0 0 0 0 0 1 3 4 2
E3A01005 00000114 0 1 0 0 0 0 0 0 0 1 5 0
E0DAB00C 00000118 0 0 5 1 0 0 0 1 1 B C A
E20120F3 0000011C 0 0 6 1 0 0 0 0 0 2 3 1
E1834005 00000120 0 0 7 1 0 0 0 0 1 4 5 3
E0367008 00000124 0 0 8 1 0 0 0 1 1 7 8 6
E3E0900A 00000128 0 0 9 1 0 0 0 0 0 9 A 0
E1520003 0000012C 0 0 4 0 0 0 0 1 1 0 3 2
E3140001 00000130 0 0 6 0 0 0 0 1 0 0 1 4
E69DE004 00000134 0 0 2 1 1 0 0 0 0 E 4 D
E68DE008 00000138 0 0 2 0 0 1 0 0 1 E E D
EA000010 0000013C 0 0 0 0 0 0 1 0 0 0 0 0
10923004 00000140 0 0 2 1 0 0 0 1 1 3 4 2
C68DE008 00000144 4 0 0 0 0 0 0 0 0 E 8 D

/* sources.f */
hdl/decodePkg.sv
hdl/decodeBuses.sv
hdl/fetchDecodeReg.sv
hdl/controlUnit.sv
hdl/conditionCheck.sv
hdl/registerFile.sv
hdl/decodeStage.sv
hdl/decodeExecuteReg.sv
hdl/decodeTop.sv
verification/decodeTb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - hdl/decodePkg.sv
      - hdl/decodeBuses.sv
      - hdl/fetchDecodeReg.sv
      - hdl/controlUnit.sv
      - hdl/conditionCheck.sv
      - hdl/registerFile.sv
      - hdl/decodeStage.sv
      - hdl/decodeExecuteReg.sv
      - hdl/decodeTop.sv
  - target: test
    files:
      - verification/decodeTb.sv

/* verification/decodeTb.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeTb import decodePkg::*; ();

    localparam int patternCount = 18;
    localparam int fieldCount   = 14;
    localparam int fixedCount   = 6;                     // Items streamed with outReady held high
    localparam int cycleLimit   = 40 * patternCount + 100;

    // Columns of the pattern file
    localparam int fInstr = 0, fPc = 1, fStatus = 2, fHazard = 3, fCmd = 4, fWb = 5;
    localparam int fMemRead = 6, fMemWrite = 7, fBranch = 8, fSFlag = 9, fTwoSrc = 10;
    localparam int fDest = 11, fSrc2 = 12, fRn = 13;

    logic clk, reset, inValid, inReady, hazard, wbEnable, outReady;
    word_t instruction, pc, wbValue, outPc, valRn, valRm;
    status_t status;
    regAddr_t wbDest, dest, src2Reg, rn;
    logic outValid, twoSrc, sFlag, branch, memWrite, memRead, writeBack, immediate;
    exeCmd_t exeCmd;
    logic [11:0] shiftOperand;
    logic [23:0] imm24;

    logic [31:0]  patternMem [patternCount*fieldCount];
    logic [154:0] outFields, heldFields;
    logic         stalled = 1'b0;
    int errors = 0, cycles = 0, inCount = 0, outCount = 0, decodeIdx;
    int pendingQ[$];
    int inEdgeQ[$];

    decodeTop #(.regCount(16)) UUT (.*);

    assign outFields = {outPc, valRn, valRm, twoSrc, sFlag, branch, exeCmd, memWrite, memRead,
                        writeBack, dest, immediate, src2Reg, rn, shiftOperand, imm24};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] patternField(input int idx, input int col);
        return patternMem[idx*fieldCount + col];
    endfunction

    function automatic word_t preloadValue(input int r);
        return 32'hC0DE0000 + r * 32'h00010001;          // Distinct per register
    endfunction

    task automatic compareField(input string name, input int idx, input logic [31:0] got,
                                input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0t: pattern %0d %s is %h, expected %h",
                     $time, idx, name, got, expected);
        end
    endtask

    // ########################################
    // Output checks
    // ########################################
    task automatic checkOutput();
        int idx;
        int inEdge;
        logic [31:0] instr;
        if (pendingQ.size() == 0) begin
            errors++;
            $display("Output item at %0t has no matching input", $time);
        end else begin
            idx    = pendingQ.pop_front();
            inEdge = inEdgeQ.pop_front();
            instr  = patternField(idx, fInstr);
            if (idx < fixedCount && cycles - inEdge != 2) begin
                errors++;
                $display("mismatch at %0t: pattern %0d left after %0d edges, expected 2",
                         $time, idx, cycles - inEdge);
            end
            compareField("pc", idx, outPc, patternField(idx, fPc));
            compareField("exeCmd", idx, exeCmd, patternField(idx, fCmd));
            compareField("writeBack", idx, writeBack, patternField(idx, fWb));
            compareField("memRead", idx, memRead, patternField(idx, fMemRead));
            compareField("memWrite", idx, memWrite, patternField(idx, fMemWrite));
            compareField("branch", idx, branch, patternField(idx, fBranch));
            compareField("sFlag", idx, sFlag, patternField(idx, fSFlag));
            compareField("twoSrc", idx, twoSrc, patternField(idx, fTwoSrc));
            compareField("dest", idx, dest, patternField(idx, fDest));
            compareField("src2Reg", idx, src2Reg, patternField(idx, fSrc2));
            compareField("rn", idx, rn, patternField(idx, fRn));
            compareField("valRn", idx, valRn, preloadValue(patternField(idx, fRn)));
            compareField("valRm", idx, valRm, preloadValue(patternField(idx, fSrc2)));
            compareField("immediate", idx, immediate, instr[25]);
            compareField("shiftOperand", idx, shiftOperand, instr[11:0]);
            compareField("imm24", idx, imm24, instr[23:0]);
        end
        outCount++;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            errors++;
            $display("Timeout after %0d cycles, %0d of %0d items came out",
                     cycles, outCount, patternCount);
            $display("Errors: %0d", errors);
            $display("Verification failed");
            $finish;
        end else if (!reset) begin
            if (stalled && outFields !== heldFields) begin
                errors++;
                $display("mismatch at %0t: output changed while stalled", $time);
            end
            stalled    = outValid && !outReady;
            heldFields = outFields;
            if (inValid && inReady) begin
                pendingQ.push_back(inCount);             // Order of acceptance
                inEdgeQ.push_back(cycles);
                inCount++;
            end
            if (outValid && outReady) begin
                checkOutput();
            end
        end
    end

    // Status and hazard follow the item that sits in decode
    always @(negedge clk) begin
        decodeIdx = outCount + ((outValid === 1'b1) ? 1 : 0);
        if (decodeIdx < patternCount) begin
            status = status_t'(patternField(decodeIdx, fStatus));
            hazard = patternField(decodeIdx, fHazard) != 0;
        end
    end

    // ########################################
    // Stimulus
    // ########################################
    task automatic preloadRegisters();
        for (int r = 0; r < 16; r++) begin
            wbEnable = 1'b1;
            wbDest   = regAddr_t'(r);
            wbValue  = preloadValue(r);
            @(negedge clk);
        end
        wbEnable = 1'b0;
    endtask

    task automatic sendPattern(input int idx, input bit randomReady);
        instruction = patternField(idx, fInstr);
        pc          = patternField(idx, fPc);
        inValid     = 1'b1;
        do begin
            @(negedge clk);
            if (randomReady) outReady = ($urandom % 2) == 1;
        end while (inCount <= idx);
        if (randomReady && ($urandom % 4) == 0) begin
            inValid = 1'b0;                              // Idle gap
            @(negedge clk);
            outReady = ($urandom % 2) == 1;
        end
    endtask

    initial begin
        void'($urandom(25));
        $readmemh("verification/decodePatterns.txt", patternMem);
        reset       = 1'b1;
        inValid     = 1'b0;
        instruction = '0;
        pc          = '0;
        hazard      = 1'b0;
        status      = '0;
        wbEnable    = 1'b0;
        wbDest      = '0;
        wbValue     = '0;
        outReady    = 1'b1;
        if ($isunknown(patternMem[patternCount*fieldCount-1])) begin
            errors++;
            $display("Pattern file is missing or has fewer than %0d lines", patternCount);
        end
        repeat (8) begin
            @(negedge clk);
            if (outValid !== 1'b0) begin
                errors++;
                $display("mismatch at %0t: outValid high during reset", $time);
            end
        end
        reset = 1'b0;
        @(negedge clk);
        if (outValid !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: outValid high right after reset", $time);
        end
        preloadRegisters();
        for (int i = 0; i < fixedCount; i++) sendPattern(i, 1'b0);
        inValid = 1'b0;
        while (outCount < fixedCount) @(negedge clk);
        for (int i = fixedCount; i < patternCount; i++) sendPattern(i, 1'b1);
        inValid = 1'b0;
        while (outCount < patternCount) begin
            @(negedge clk);
            outReady = ($urandom % 2) == 1;
        end
        outReady = 1'b1;
        repeat (4) @(negedge clk);                       // Catch any extra item
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/decodeTop.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeTop import decodePkg::*; #(
    parameter int regCount = 16
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        inValid,
    output logic        inReady,
    input  word_t       instruction,
    input  word_t       pc,
    input  logic        hazard,
    input  status_t     status,
    input  logic        wbEnable,
    input  regAddr_t    wbDest,
    input  word_t       wbValue,
    output logic        outValid,
    output word_t       outPc,         // Pc of the decoded item
    output word_t       valRn,
    output word_t       valRm,
    output logic        twoSrc,
    output logic        sFlag,
    output logic        branch,
    output exeCmd_t     exeCmd,
    output logic        memWrite,
    output logic        memRead,
    output logic        writeBack,
    output regAddr_t    dest,
    output logic        immediate,
    output regAddr_t    src2Reg,
    output regAddr_t    rn,
    output logic [11:0] shiftOperand,
    output logic [23:0] imm24,
    input  logic        outReady
);

    fetchBus   fetchLink ();
    decodedBus decodedLink ();

    fetchDecodeReg fetchReg (
        .clk(clk), .reset(reset), .inValid(inValid), .inReady(inReady),
        .instruction(instruction), .pc(pc), .fetchOut(fetchLink.source)
    );

    decodeStage #(.regCount(regCount)) decode (
        .clk(clk), .reset(reset), .hazard(hazard), .status(status),
        .wbEnable(wbEnable), .wbDest(wbDest), .wbValue(wbValue),
        .fetchIn(fetchLink.sink), .decodedOut(decodedLink.source)
    );

    decodeExecuteReg executeReg (
        .clk(clk), .reset(reset), .decodedIn(decodedLink.sink),
        .outValid(outValid), .pc(outPc), .valRn(valRn), .valRm(valRm),
        .twoSrc(twoSrc), .sFlag(sFlag), .branch(branch), .exeCmd(exeCmd),
        .memWrite(memWrite), .memRead(memRead), .writeBack(writeBack),
        .dest(dest), .immediate(immediate), .src2Reg(src2Reg), .rn(rn),
        .shiftOperand(shiftOperand), .imm24(imm24), .outReady(outReady)
    );

endmodule

`default_nettype wire

/* hdl/decodeExecuteReg.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeExecuteReg import decodePkg::*; (
    input  logic        clk,
    input  logic        reset,
    decodedBus.sink     decodedIn,
    output logic        outValid,
    output word_t       pc,
    output word_t       valRn,
    output word_t       valRm,
    output logic        twoSrc,
    output logic        sFlag,
    output logic        branch,
    output exeCmd_t     exeCmd,
    output logic        memWrite,
    output logic        memRead,
    output logic        writeBack,
    output regAddr_t    dest,
    output logic        immediate,
    output regAddr_t    src2Reg,
    output regAddr_t    rn,
    output logic [11:0] shiftOperand,
    output logic [23:0] imm24,
    input  logic        outReady
);

    assign decodedIn.ready = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else if (decodedIn.ready) begin
            outValid <= decodedIn.valid;
        end
    end

    // ########################################
    // Payload, loaded on transfer
    // ########################################
    always_ff @(posedge clk) begin
        if (decodedIn.valid && decodedIn.ready) begin
            pc           <= decodedIn.pc;
            valRn        <= decodedIn.valRn;
            valRm        <= decodedIn.valRm;
            twoSrc       <= decodedIn.twoSrc;
            sFlag        <= decodedIn.sFlag;
            branch       <= decodedIn.branch;
            exeCmd       <= decodedIn.exeCmd;
            memWrite     <= decodedIn.memWrite;
            memRead      <= decodedIn.memRead;
            writeBack    <= decodedIn.writeBack;
            dest         <= decodedIn.dest;
            immediate    <= decodedIn.immediate;
            src2Reg      <= decodedIn.src2Reg;
            rn           <= decodedIn.rn;
            shiftOperand <= decodedIn.shiftOperand;
            imm24        <= decodedIn.imm24;
        end
    end

endmodule

`default_nettype wire

/* hdl/decodeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStage import decodePkg::*; #(
    parameter int regCount = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       hazard,
    input  status_t    status,
    input  logic       wbEnable,
    input  regAddr_t   wbDest,
    input  word_t      wbValue,
    fetchBus.sink      fetchIn,
    decodedBus.source  decodedOut
);

    // ########################################
    // Instruction fields
    // ########################################
    word_t      instr;
    logic [3:0] cond;
    logic [1:0] mode;
    logic [3:0] opcode;
    logic       sBit;
    logic       immBit;
    regAddr_t   rn, rd, rm, src2Reg;
    logic       pass;
    logic       nop;

    exeCmd_t    cuCmd;
    logic       cuS, cuB, cuMemWrite, cuMemRead, cuWriteBack;

    assign instr  = fetchIn.instruction;
    assign cond   = instr[31:28];
    assign mode   = instr[27:26];
    assign immBit = instr[25];
    assign opcode = instr[24:21];
    assign sBit   = instr[20];
    assign rn     = instr[19:16];
    assign rd     = instr[15:12];
    assign rm     = instr[3:0];

    controlUnit ctrl (
        .mode(mode), .opcode(opcode), .sBit(sBit),
        .exeCmd(cuCmd), .sFlag(cuS), .branch(cuB),
        .memWrite(cuMemWrite), .memRead(cuMemRead), .writeBack(cuWriteBack)
    );

    conditionCheck condCheck (.cond(cond), .status(status), .pass(pass));

    assign nop = !pass || hazard;  // Bundle becomes a bubble

    assign decodedOut.exeCmd    = nop ? cmdNone : cuCmd;
    assign decodedOut.sFlag     = cuS && !nop;
    assign decodedOut.branch    = cuB && !nop;
    assign decodedOut.memWrite  = cuMemWrite && !nop;
    assign decodedOut.memRead   = cuMemRead && !nop;
    assign decodedOut.writeBack = cuWriteBack && !nop;

    // STR reads the stored value from rd
    assign src2Reg = decodedOut.memWrite ? rd : rm;

    registerFile #(.regCount(regCount)) regFile (
        .clk(clk), .reset(reset),
        .writeEnable(wbEnable), .writeAddr(wbDest), .writeData(wbValue),
        .readAddr1(rn), .readAddr2(src2Reg),
        .readData1(decodedOut.valRn), .readData2(decodedOut.valRm)
    );

    assign decodedOut.twoSrc       = !immBit || decodedOut.memWrite;
    assign decodedOut.src2Reg      = src2Reg;
    assign decodedOut.pc           = fetchIn.pc;
    assign decodedOut.dest         = rd;
    assign decodedOut.rn           = rn;
    assign decodedOut.immediate    = immBit;
    assign decodedOut.shiftOperand = instr[11:0];
    assign decodedOut.imm24        = instr[23:0];

    // Handshake passes straight through
    assign decodedOut.valid = fetchIn.valid;
    assign fetchIn.ready    = decodedOut.ready;

endmodule

`default_nettype wire

/* hdl/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile import decodePkg::*; #(
    parameter int regCount = 16
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     writeEnable,
    input  regAddr_t writeAddr,
    input  word_t    writeData,
    input  regAddr_t readAddr1,
    input  regAddr_t readAddr2,
    output word_t    readData1,
    output word_t    readData2
);

    word_t regs [regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Write-back value goes straight to a same-cycle reader
    assign readData1 = (writeEnable && writeAddr == readAddr1) ? writeData
                                                               : regs[readAddr1];
    assign readData2 = (writeEnable && writeAddr == readAddr2) ? writeData
                                                               : regs[readAddr2];

endmodule

`default_nettype wire

/* hdl/conditionCheck.sv */
`timescale 1ns/1ns
`default_nettype none

module conditionCheck import decodePkg::*; (
    input  logic [3:0] cond,
    input  status_t    status,
    output logic       pass
);

    logic n, z, c, v;

    assign {n, z, c, v} = status;

    always_comb begin
        case (cond)
            4'd0:    pass = z;                  // EQ
            4'd1:    pass = !z;                 // NE
            4'd2:    pass = c;                  // CS
            4'd3:    pass = !c;                 // CC
            4'd4:    pass = n;                  // MI
            4'd5:    pass = !n;                 // PL
            4'd6:    pass = v;                  // VS
            4'd7:    pass = !v;                 // VC
            4'd8:    pass = c && !z;            // HI
            4'd9:    pass = !c || z;            // LS
            4'd10:   pass = n == v;             // GE
            4'd11:   pass = n != v;             // LT
            4'd12:   pass = !z && (n == v);     // GT
            4'd13:   pass = z || (n != v);      // LE
            default: pass = 1'b1;               // AL and code 15
        endcase
    end

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit import decodePkg::*; (
    input  logic [1:0] mode,
    input  logic [3:0] opcode,
    input  logic       sBit,
    output exeCmd_t    exeCmd,
    output logic       sFlag,
    output logic       branch,
    output logic       memWrite,
    output logic       memRead,
    output logic       writeBack
);

    always_comb begin
        exeCmd    = cmdNone;
        sFlag     = 1'b0;
        branch    = 1'b0;
        memWrite  = 1'b0;
        memRead   = 1'b0;
        writeBack = 1'b0;
        case (mode)
            modeData: begin
                sFlag     = sBit;
                writeBack = 1'b1;
                case (opcode)
                    opMov:   exeCmd = cmdMov;
                    opMvn:   exeCmd = cmdMvn;
                    opAdd:   exeCmd = cmdAdd;
                    opAdc:   exeCmd = cmdAdc;
                    opSub:   exeCmd = cmdSub;
                    opSbc:   exeCmd = cmdSbc;
                    opAnd:   exeCmd = cmdAnd;
                    opOrr:   exeCmd = cmdOrr;
                    opEor:   exeCmd = cmdEor;
                    opCmp: begin
                        exeCmd    = cmdSub;  // Flags only
                        writeBack = 1'b0;
                    end
                    opTst: begin
                        exeCmd    = cmdAnd;
                        writeBack = 1'b0;
                    end
                    default: begin
                        sFlag     = 1'b0;
                        writeBack = 1'b0;
                    end
                endcase
            end
            modeMemory: begin
                exeCmd    = cmdAdd;          // Base plus offset
                memRead   = sBit;            // LDR
                writeBack = sBit;
                memWrite  = !sBit;           // STR
            end
            modeBranch: branch = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/fetchDecodeReg.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchDecodeReg import decodePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     inValid,
    output logic     inReady,
    input  word_t    instruction,
    input  word_t    pc,
    fetchBus.source  fetchOut
);

    logic  holdValid;
    word_t holdInstruction;
    word_t holdPc;

    // Free when empty or when the held item leaves this cycle
    assign inReady = !holdValid || fetchOut.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            holdValid <= 1'b0;
        end else if (inReady) begin
            holdValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            holdInstruction <= instruction;  // Capture on transfer only
            holdPc          <= pc;
        end
    end

    assign fetchOut.valid       = holdValid;
    assign fetchOut.instruction = holdInstruction;
    assign fetchOut.pc          = holdPc;

endmodule

`default_nettype wire

/* hdl/decodeBuses.sv */
`timescale 1ns/1ns
`default_nettype none

// ########################################
// Fetch to decode
// ########################################
interface fetchBus import decodePkg::*; ();
    logic  valid;
    logic  ready;
    word_t instruction;
    word_t pc;

    modport source (output valid, output instruction, output pc, input ready);
    modport sink   (input valid, input instruction, input pc, output ready);
endinterface

// ########################################
// Decode to execute
// ########################################
interface decodedBus import decodePkg::*; ();
    logic        valid;
    logic        ready;
    word_t       pc;
    word_t       valRn;
    word_t       valRm;
    logic        twoSrc;
    logic        sFlag;
    logic        branch;
    exeCmd_t     exeCmd;
    logic        memWrite;
    logic        memRead;
    logic        writeBack;
    regAddr_t    dest;
    logic        immediate;
    regAddr_t    src2Reg;
    regAddr_t    rn;
    logic [11:0] shiftOperand;
    logic [23:0] imm24;

    modport source (output valid, pc, valRn, valRm, twoSrc, sFlag, branch, exeCmd,
                    memWrite, memRead, writeBack, dest, immediate, src2Reg, rn,
                    shiftOperand, imm24, input ready);
    modport sink   (input valid, pc, valRn, valRm, twoSrc, sFlag, branch, exeCmd,
                    memWrite, memRead, writeBack, dest, immediate, src2Reg, rn,
                    shiftOperand, imm24, output ready);
endinterface

`default_nettype wire

/* hdl/decodePkg.sv */
`default_nettype none

package decodePkg;

    // ########################################
    // Widths and vector types
    // ########################################
    parameter int dataWidth    = 32;
    parameter int regAddrWidth = 4;

    typedef logic [dataWidth-1:0]    word_t;     // Instruction, pc and register values
    typedef logic [regAddrWidth-1:0] regAddr_t;  // Register index
    typedef logic [3:0]              status_t;   // NZCV with N as the high bit
    typedef logic [3:0]              exeCmd_t;   // Command for the execute ALU

    // ########################################
    // Data-processing opcodes in bits 24:21
    // ########################################
    localparam logic [3:0] opAnd = 4'b0000;
    localparam logic [3:0] opEor = 4'b0001;
    localparam logic [3:0] opSub = 4'b0010;
    localparam logic [3:0] opAdd = 4'b0100;
    localparam logic [3:0] opAdc = 4'b0101;
    localparam logic [3:0] opSbc = 4'b0110;
    localparam logic [3:0] opTst = 4'b1000;
    localparam logic [3:0] opCmp = 4'b1010;
    localparam logic [3:0] opOrr = 4'b1100;
    localparam logic [3:0] opMov = 4'b1101;
    localparam logic [3:0] opMvn = 4'b1111;

    // Execute commands
    localparam exeCmd_t cmdNone = 4'd0;
    localparam exeCmd_t cmdMov  = 4'd1;
    localparam exeCmd_t cmdAdd  = 4'd2;
    localparam exeCmd_t cmdAdc  = 4'd3;
    localparam exeCmd_t cmdSub  = 4'd4;
    localparam exeCmd_t cmdSbc  = 4'd5;
    localparam exeCmd_t cmdAnd  = 4'd6;
    localparam exeCmd_t cmdOrr  = 4'd7;
    localparam exeCmd_t cmdEor  = 4'd8;
    localparam exeCmd_t cmdMvn  = 4'd9;

    // Instruction classes in bits 27:26
    localparam logic [1:0] modeData   = 2'd0;
    localparam logic [1:0] modeMemory = 2'd1;
    localparam logic [1:0] modeBranch = 2'd2;

endpackage

`default_nettype wire
